// ==== Bender.yml ====
package:
  name: lsu_top

export_include_dirs:
  - .

sources:
  - lsu_pkg.sv
  - data_memory_interface.sv
  - data_memory.sv
  - agu_stage.sv
  - mem_stage.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu_top.sv

// ==== agu_stage.sv ====
////////////////////////////////////////
// address generation stage
// effective address, alignment check and
// the first pipeline register
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module agu_stage (
  input  logic             clock,
  input  logic             rst,
  input  logic             req_valid,
  input  lsu_pkg::lsu_op_e req_op,
  input  lsu_pkg::format_t req_format,
  input  lsu_pkg::addr_t   req_base,
  input  lsu_pkg::offset_t req_offset,
  input  lsu_pkg::word_t   req_store_data,
  input  lsu_pkg::tag_t    req_tag,
  output logic             agu_valid,
  output lsu_pkg::lsu_op_e agu_op,
  output lsu_pkg::format_t agu_format,
  output lsu_pkg::addr_t   agu_address,
  output lsu_pkg::word_t   agu_store_data,
  output lsu_pkg::tag_t    agu_tag,
  output logic             agu_fault
);

  lsu_pkg::addr_t eff_address;
  logic           misaligned;
  logic           illegal;

  // base plus sign-extended immediate
  assign eff_address = req_base +
                       {{(`LSU_XLEN-`LSU_OFFSET_W){req_offset[`LSU_OFFSET_W-1]}}, req_offset};

  // alignment depends on the access size
  always_comb begin
    case (req_format[1:0])
      lsu_pkg::SIZE_BYTE: misaligned = 1'b0;
      lsu_pkg::SIZE_HALF: misaligned = eff_address[0];
      lsu_pkg::SIZE_WORD: misaligned = |eff_address[1:0];
      default:            misaligned = 1'b0;
    endcase
  end

  // size 3 is reserved
  // no unsigned form exists for stores
  assign illegal = (req_format[1:0] == 2'b11) ||
                   (req_op == lsu_pkg::LSU_STORE && req_format[2]);

  // valid and fault are control
  always_ff @(posedge clock) begin
    if (rst) begin
      agu_valid <= 1'b0;
      agu_fault <= 1'b0;
    end else begin
      agu_valid <= req_valid;
      agu_fault <= req_valid & (misaligned | illegal);
    end
  end

  // request fields only move on a strobe
  always_ff @(posedge clock) begin
    if (req_valid) begin
      agu_op         <= req_op;
      agu_format     <= req_format;
      agu_address    <= eff_address;
      agu_store_data <= req_store_data;
      agu_tag        <= req_tag;
    end
  end

  // fault decision needs a fully known request
  a_request_known: assert property (
    @(posedge clock) disable iff (rst)
      req_valid |-> !$isunknown({req_op, req_format, req_base, req_offset})
  );

endmodule

`default_nettype wire

// ==== data_memory.sv ====
////////////////////////////////////////
// data memory
// word RAM, async read, byte-enabled write
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module data_memory (
  input  logic              clock,
  input  lsu_pkg::addr_t    bus_address,
  input  lsu_pkg::word_t    bus_write_data,
  input  lsu_pkg::byte_en_t bus_byte_enable,
  input  logic              bus_read_enable,
  input  logic              bus_write_enable,
  output lsu_pkg::word_t    bus_read_data
);

  // word storage, contents not reset
  lsu_pkg::word_t mem [`LSU_MEM_WORDS];

  // byte address to word index
  // upper address bits wrap
  logic [`LSU_MEM_AW-1:0] word_index;

  assign word_index = bus_address[`LSU_MEM_AW+1:2];

  // only enabled lanes change
  always_ff @(posedge clock) begin
    if (bus_write_enable) begin
      for (int lane = 0; lane < `LSU_XLEN/8; lane++) begin
        if (bus_byte_enable[lane]) begin
          mem[word_index][8*lane +: 8] <= bus_write_data[8*lane +: 8];
        end
      end
    end
  end

  // read is combinational
  // idle bus returns zero
  assign bus_read_data = bus_read_enable ? mem[word_index] : '0;

  // one access per cycle from the memory stage
  // x before the first reset edge counts as idle
  a_no_read_write: assert property (
    @(posedge clock) !(bus_read_enable === 1'b1 && bus_write_enable === 1'b1)
  );

endmodule

`default_nettype wire

// ==== data_memory_interface.sv ====
////////////////////////////////////////
// data memory interface
// lane steering for stores, alignment and
// extension for loads
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module data_memory_interface (
  input  logic              read_enable,
  input  logic              write_enable,
  input  lsu_pkg::format_t  data_format,
  input  lsu_pkg::addr_t    address,
  input  lsu_pkg::word_t    write_data,
  input  lsu_pkg::word_t    bus_read_data,
  output lsu_pkg::word_t    read_data,
  output lsu_pkg::addr_t    bus_address,
  output lsu_pkg::word_t    bus_write_data,
  output lsu_pkg::byte_en_t bus_byte_enable,
  output logic              bus_read_enable,
  output logic              bus_write_enable
);

  // byte offset times eight
  logic [4:0]     lane_shift;
  lsu_pkg::word_t position_fix;
  logic           sign_bit;

  assign lane_shift = {address[1:0], 3'b000};

  // request side of the bus
  always_comb begin
    bus_address      = address;
    bus_read_enable  = read_enable;
    bus_write_enable = write_enable;
    bus_write_data   = write_data << lane_shift;

    // lanes touched by the access
    case (data_format[1:0])
      lsu_pkg::SIZE_BYTE: bus_byte_enable = 4'b0001 << address[1:0];
      lsu_pkg::SIZE_HALF: bus_byte_enable = 4'b0011 << address[1:0];
      lsu_pkg::SIZE_WORD: bus_byte_enable = 4'b1111 << address[1:0];
      default:            bus_byte_enable = '0;
    endcase
  end

  // addressed bytes down to lane zero
  assign position_fix = bus_read_data >> lane_shift;

  // response side, extend per format
  always_comb begin
    sign_bit = 1'b0;
    case (data_format[1:0])
      lsu_pkg::SIZE_BYTE: begin
        sign_bit  = ~data_format[2] & position_fix[7];
        read_data = {{(`LSU_XLEN-8){sign_bit}}, position_fix[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        sign_bit  = ~data_format[2] & position_fix[15];
        read_data = {{(`LSU_XLEN-16){sign_bit}}, position_fix[15:0]};
      end
      lsu_pkg::SIZE_WORD: read_data = position_fix;
      // reserved size never reaches the bus
      default:            read_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== lsu_defines.svh ====
////////////////////////////////////////
// lsu width and depth macros
// shared sizing for the load/store path
////////////////////////////////////////

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and byte address width
`define LSU_XLEN 32

// signed immediate offset width
`define LSU_OFFSET_W 12

// memory depth in 32-bit words
`define LSU_MEM_WORDS 256

// word index width, log2 of depth
`define LSU_MEM_AW 8

// destination register tag width
`define LSU_TAG_W 5

`endif

// ==== lsu_pkg.sv ====
////////////////////////////////////////
// lsu package
// types shared by the load/store path
////////////////////////////////////////

`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

  // data word and byte address
  typedef logic [`LSU_XLEN-1:0] word_t;
  typedef logic [`LSU_XLEN-1:0] addr_t;

  // immediate from the instruction, sign matters
  typedef logic signed [`LSU_OFFSET_W-1:0] offset_t;

  // one bit per byte lane
  typedef logic [`LSU_XLEN/8-1:0] byte_en_t;

  // destination register tag
  typedef logic [`LSU_TAG_W-1:0] tag_t;

  // funct3 data format
  // bit 2 set means zero-extend on load
  typedef logic [2:0] format_t;

  // access size in the low two format bits
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

endpackage

`default_nettype wire

// ==== lsu_top.sv ====
////////////////////////////////////////
// load/store unit top
// agu stage feeding the memory stage
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_top (
  input  logic             clock,
  input  logic             rst,
  input  logic             req_valid,
  input  lsu_pkg::lsu_op_e req_op,
  input  lsu_pkg::format_t req_format,
  input  lsu_pkg::addr_t   req_base,
  input  lsu_pkg::offset_t req_offset,
  input  lsu_pkg::word_t   req_store_data,
  input  lsu_pkg::tag_t    req_tag,
  output logic             result_valid,
  output lsu_pkg::word_t   result_data,
  output lsu_pkg::tag_t    result_tag,
  output logic             result_fault,
  output logic             result_is_store
);

  // stage 1 to stage 2
  logic             agu_valid;
  lsu_pkg::lsu_op_e agu_op;
  lsu_pkg::format_t agu_format;
  lsu_pkg::addr_t   agu_address;
  lsu_pkg::word_t   agu_store_data;
  lsu_pkg::tag_t    agu_tag;
  logic             agu_fault;

  agu_stage u_agu_stage (
    .clock          (clock),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_op         (req_op),
    .req_format     (req_format),
    .req_base       (req_base),
    .req_offset     (req_offset),
    .req_store_data (req_store_data),
    .req_tag        (req_tag),
    .agu_valid      (agu_valid),
    .agu_op         (agu_op),
    .agu_format     (agu_format),
    .agu_address    (agu_address),
    .agu_store_data (agu_store_data),
    .agu_tag        (agu_tag),
    .agu_fault      (agu_fault)
  );

  mem_stage u_mem_stage (
    .clock           (clock),
    .rst             (rst),
    .agu_valid       (agu_valid),
    .agu_op          (agu_op),
    .agu_format      (agu_format),
    .agu_address     (agu_address),
    .agu_store_data  (agu_store_data),
    .agu_tag         (agu_tag),
    .agu_fault       (agu_fault),
    .result_valid    (result_valid),
    .result_data     (result_data),
    .result_tag      (result_tag),
    .result_fault    (result_fault),
    .result_is_store (result_is_store)
  );

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
////////////////////////////////////////
// memory stage
// bus access and the result register
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module mem_stage (
  input  logic             clock,
  input  logic             rst,
  input  logic             agu_valid,
  input  lsu_pkg::lsu_op_e agu_op,
  input  lsu_pkg::format_t agu_format,
  input  lsu_pkg::addr_t   agu_address,
  input  lsu_pkg::word_t   agu_store_data,
  input  lsu_pkg::tag_t    agu_tag,
  input  logic             agu_fault,
  output logic             result_valid,
  output lsu_pkg::word_t   result_data,
  output lsu_pkg::tag_t    result_tag,
  output logic             result_fault,
  output logic             result_is_store
);

  logic              read_enable;
  logic              write_enable;
  lsu_pkg::word_t    read_data;
  lsu_pkg::addr_t    bus_address;
  lsu_pkg::word_t    bus_write_data;
  lsu_pkg::byte_en_t bus_byte_enable;
  logic              bus_read_enable;
  logic              bus_write_enable;
  lsu_pkg::word_t    bus_read_data;

  // faulted requests never touch memory
  assign read_enable  = agu_valid & ~agu_fault & (agu_op == lsu_pkg::LSU_LOAD);
  assign write_enable = agu_valid & ~agu_fault & (agu_op == lsu_pkg::LSU_STORE);

  data_memory_interface u_data_memory_interface (
    .read_enable      (read_enable),
    .write_enable     (write_enable),
    .data_format      (agu_format),
    .address          (agu_address),
    .write_data       (agu_store_data),
    .bus_read_data    (bus_read_data),
    .read_data        (read_data),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

  data_memory u_data_memory (
    .clock            (clock),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_data    (bus_read_data)
  );

  always_ff @(posedge clock) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= agu_valid;
    end
  end

  // payload is qualified by result_valid
  // stores and faults give zero data
  always_ff @(posedge clock) begin
    result_data     <= read_enable ? read_data : '0;
    result_tag      <= agu_tag;
    result_fault    <= agu_fault;
    result_is_store <= (agu_op == lsu_pkg::LSU_STORE);
  end

  // an access that reaches the bus covers exactly its size in lanes
  a_lanes_match_size: assert property (
    @(posedge clock) disable iff (rst)
      (read_enable || write_enable) |->
        $countones(bus_byte_enable) == (1 << agu_format[1:0])
  );

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
lsu_pkg.sv
data_memory_interface.sv
data_memory.sv
agu_stage.sv
mem_stage.sv
lsu_top.sv
tb_lsu_top.sv

// ==== tb_lsu_top.sv ====
////////////////////////////////////////
// load/store unit testbench
// directed table, then LCG traffic
// against a byte shadow memory
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_top;

  localparam lsu_pkg::lsu_op_e LD = lsu_pkg::LSU_LOAD;
  localparam lsu_pkg::lsu_op_e ST = lsu_pkg::LSU_STORE;

  typedef struct packed {
    lsu_pkg::lsu_op_e op;
    lsu_pkg::format_t fmt;
    lsu_pkg::addr_t   base;
    lsu_pkg::offset_t offset;
    lsu_pkg::word_t   data;
    lsu_pkg::word_t   exp_data;
    logic             exp_fault;
  } entry_t;

  logic             clock;
  logic             rst;
  logic             req_valid;
  lsu_pkg::lsu_op_e req_op;
  lsu_pkg::format_t req_format;
  lsu_pkg::addr_t   req_base;
  lsu_pkg::offset_t req_offset;
  lsu_pkg::word_t   req_store_data;
  lsu_pkg::tag_t    req_tag;
  logic             result_valid;
  lsu_pkg::word_t   result_data;
  lsu_pkg::tag_t    result_tag;
  logic             result_fault;
  logic             result_is_store;

  // byte image of the data memory
  logic [7:0] shadow [`LSU_MEM_WORDS*4];
  entry_t     stim_table [$];

  // expectations in issue order
  lsu_pkg::word_t exp_data_q [$];
  lsu_pkg::tag_t  exp_tag_q [$];
  logic           exp_fault_q [$];
  logic           exp_store_q [$];
  int             exp_cycle_q [$];

  int          cycle_count;
  int          error_count;
  int          next_tag;
  int          expect_cycle;
  logic [31:0] lcg_state;

  lsu_top u_lsu_top (
    .clock           (clock),
    .rst             (rst),
    .req_valid       (req_valid),
    .req_op          (req_op),
    .req_format      (req_format),
    .req_base        (req_base),
    .req_offset      (req_offset),
    .req_store_data  (req_store_data),
    .req_tag         (req_tag),
    .result_valid    (result_valid),
    .result_data     (result_data),
    .result_tag      (result_tag),
    .result_fault    (result_fault),
    .result_is_store (result_is_store)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function lsu_pkg::addr_t sign_extend(input lsu_pkg::offset_t offset);
    return {{(`LSU_XLEN-`LSU_OFFSET_W){offset[`LSU_OFFSET_W-1]}}, offset};
  endfunction

  task check_word(input string name, input lsu_pkg::word_t expected,
                  input lsu_pkg::word_t actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task check_tag(input string name, input lsu_pkg::tag_t expected,
                 input lsu_pkg::tag_t actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // reference access on the byte image
  // faults leave the image untouched
  task automatic run_model(input lsu_pkg::lsu_op_e op, input lsu_pkg::format_t fmt,
                           input lsu_pkg::addr_t addr, input lsu_pkg::word_t data,
                           output lsu_pkg::word_t result, output logic fault);
    int             nbytes;
    int             idx;
    lsu_pkg::word_t raw;
    nbytes = 1 << fmt[1:0];
    idx    = addr[`LSU_MEM_AW+1:0];
    raw    = '0;
    result = '0;
    fault  = (fmt[1:0] == 2'b11) || (op == ST && fmt[2]) || ((addr & (nbytes - 1)) != 0);
    if (!fault) begin
      for (int i = 0; i < nbytes; i++) begin
        if (op == ST) begin
          shadow[idx + i] = data[8*i +: 8];
        end else begin
          raw[8*i +: 8] = shadow[idx + i];
        end
      end
      // unused upper bytes stay zero for unsigned loads
      if (op == LD) begin
        result = raw;
        if (!fmt[2] && fmt[1:0] == 2'b00) begin
          result = {{24{raw[7]}}, raw[7:0]};
        end
        if (!fmt[2] && fmt[1:0] == 2'b01) begin
          result = {{16{raw[15]}}, raw[15:0]};
        end
      end
    end
  endtask

  task add_entry(input lsu_pkg::lsu_op_e op, input lsu_pkg::format_t fmt,
                 input lsu_pkg::addr_t base, input lsu_pkg::offset_t offset,
                 input lsu_pkg::word_t data, input lsu_pkg::word_t exp_data,
                 input logic exp_fault);
    entry_t entry;
    entry.op        = op;
    entry.fmt       = fmt;
    entry.base      = base;
    entry.offset    = offset;
    entry.data      = data;
    entry.exp_data  = exp_data;
    entry.exp_fault = exp_fault;
    stim_table.push_back(entry);
  endtask

  // one strobe per call 2 ns after the edge
  task send_request(input lsu_pkg::lsu_op_e op, input lsu_pkg::format_t fmt,
                    input lsu_pkg::addr_t base, input lsu_pkg::offset_t offset,
                    input lsu_pkg::word_t data, input lsu_pkg::word_t exp_data,
                    input logic exp_fault);
    @(posedge clock);
    #2;
    req_valid      = 1'b1;
    req_op         = op;
    req_format     = fmt;
    req_base       = base;
    req_offset     = offset;
    req_store_data = data;
    req_tag        = lsu_pkg::tag_t'(next_tag);
    exp_data_q.push_back(exp_data);
    exp_tag_q.push_back(lsu_pkg::tag_t'(next_tag));
    exp_fault_q.push_back(exp_fault);
    exp_store_q.push_back(op == ST);
    // result due two cycles after the strobe
    exp_cycle_q.push_back(cycle_count + 2);
    next_tag++;
  endtask

  // outputs sampled mid-cycle
  always @(negedge clock) begin
    if (result_valid === 1'b1) begin
      if (exp_data_q.size() == 0) begin
        $display("ERROR t=%0t result_valid seen with no request outstanding", $time);
        error_count++;
      end else begin
        check_word("result_data", exp_data_q.pop_front(), result_data);
        check_tag("result_tag", exp_tag_q.pop_front(), result_tag);
        check_flag("result_fault", exp_fault_q.pop_front(), result_fault);
        check_flag("result_is_store", exp_store_q.pop_front(), result_is_store);
        expect_cycle = exp_cycle_q.pop_front();
        if (expect_cycle != cycle_count) begin
          $display("ERROR t=%0t result arrived in cycle %0d but was due in cycle %0d",
                   $time, cycle_count, expect_cycle);
          error_count++;
        end
      end
    end else if (rst === 1'b0 && result_valid !== 1'b0) begin
      // unknown valid only matters once reset is known low
      $display("ERROR t=%0t result_valid is unknown", $time);
      error_count++;
    end
  end

  initial begin
    logic [31:0]      r1;
    logic [31:0]      r2;
    logic [31:0]      r3;
    lsu_pkg::lsu_op_e op;
    lsu_pkg::format_t fmt;
    lsu_pkg::addr_t   addr;
    lsu_pkg::word_t   model_data;
    logic             model_fault;
    int               wait_count;
    rst            = 1'b1;
    req_valid      = 1'b0;
    req_op         = LD;
    req_format     = '0;
    req_base       = '0;
    req_offset     = '0;
    req_store_data = '0;
    req_tag        = '0;
    lcg_state      = 32'h8bc406f9;

    // word at 0x10 starts as 87 65 43 a1 and is patched to 12 34 f0 a1
    add_entry(ST, 3'd2, 32'h010, 12'h000, 32'h876543a1, 32'h00000000, 1'b0);
    add_entry(LD, 3'd2, 32'h010, 12'h000, 32'h0, 32'h876543a1, 1'b0);
    add_entry(LD, 3'd0, 32'h010, 12'h000, 32'h0, 32'hffffffa1, 1'b0);
    add_entry(LD, 3'd4, 32'h010, 12'h000, 32'h0, 32'h000000a1, 1'b0);
    add_entry(LD, 3'd0, 32'h011, 12'h000, 32'h0, 32'h00000043, 1'b0);
    add_entry(LD, 3'd4, 32'h011, 12'h000, 32'h0, 32'h00000043, 1'b0);
    add_entry(LD, 3'd0, 32'h012, 12'h000, 32'h0, 32'h00000065, 1'b0);
    add_entry(LD, 3'd4, 32'h012, 12'h000, 32'h0, 32'h00000065, 1'b0);
    add_entry(LD, 3'd4, 32'h013, 12'h000, 32'h0, 32'h00000087, 1'b0);
    add_entry(LD, 3'd0, 32'h013, 12'h000, 32'h0, 32'hffffff87, 1'b0);
    add_entry(LD, 3'd1, 32'h012, 12'h000, 32'h0, 32'hffff8765, 1'b0);
    add_entry(LD, 3'd5, 32'h012, 12'h000, 32'h0, 32'h00008765, 1'b0);
    add_entry(LD, 3'd1, 32'h010, 12'h000, 32'h0, 32'h000043a1, 1'b0);
    add_entry(LD, 3'd5, 32'h010, 12'h000, 32'h0, 32'h000043a1, 1'b0);
    add_entry(ST, 3'd0, 32'h011, 12'h000, 32'h000000f0, 32'h00000000, 1'b0);
    add_entry(ST, 3'd1, 32'h012, 12'h000, 32'h00001234, 32'h00000000, 1'b0);
    // negative offset and wrap from the top and past the depth
    add_entry(LD, 3'd2, 32'h020, 12'hff0, 32'h0, 32'h1234f0a1, 1'b0);
    add_entry(ST, 3'd2, 32'h000, 12'hffc, 32'h5a5a0ff0, 32'h00000000, 1'b0);
    add_entry(LD, 3'd2, 32'h3fc, 12'h000, 32'h0, 32'h5a5a0ff0, 1'b0);
    add_entry(LD, 3'd2, 32'h410, 12'h000, 32'h0, 32'h1234f0a1, 1'b0);
    // faults leave memory intact
    add_entry(LD, 3'd1, 32'h011, 12'h000, 32'h0, 32'h00000000, 1'b1);
    add_entry(ST, 3'd2, 32'h012, 12'h000, 32'hffffffff, 32'h00000000, 1'b1);
    add_entry(LD, 3'd3, 32'h010, 12'h000, 32'h0, 32'h00000000, 1'b1);
    add_entry(ST, 3'd4, 32'h010, 12'h000, 32'h000000ff, 32'h00000000, 1'b1);
    add_entry(LD, 3'd2, 32'h010, 12'h000, 32'h0, 32'h1234f0a1, 1'b0);

    repeat (16) @(posedge clock);
    #2;
    rst = 1'b0;

    foreach (stim_table[i]) begin
      // keep the shadow image in step with the table
      addr = stim_table[i].base + sign_extend(stim_table[i].offset);
      run_model(stim_table[i].op, stim_table[i].fmt, addr, stim_table[i].data,
                model_data, model_fault);
      send_request(stim_table[i].op, stim_table[i].fmt, stim_table[i].base,
                   stim_table[i].offset, stim_table[i].data,
                   stim_table[i].exp_data, stim_table[i].exp_fault);
    end

    // fill words 64..79 before random loads touch them
    for (int w = 0; w < 16; w++) begin
      addr = 32'h100 + 4 * w;
      r3   = next_random();
      run_model(ST, 3'd2, addr, r3, model_data, model_fault);
      send_request(ST, 3'd2, addr, 12'h000, r3, model_data, model_fault);
    end

    // draw from the upper LCG bits
    for (int n = 0; n < 200; n++) begin
      r1  = next_random();
      r2  = next_random();
      r3  = next_random();
      op  = r1[31] ? ST : LD;
      fmt = r1[30:28];
      // mostly legal with some reserved sizes left in
      if (r1[27:25] != 3'b000) begin
        if (fmt[1:0] == 2'b11) begin
          fmt[1:0] = 2'b10;
        end
        if (op == ST) begin
          fmt[2] = 1'b0;
        end
      end
      // words 64..79 with random high bits that wrap
      addr = {r3[31:10], 4'b0100, r2[19:16], r1[24:23]};
      if (r1[22:21] != 2'b00 && fmt[1:0] == 2'b01) begin
        addr[0] = 1'b0;
      end
      if (r1[22:21] != 2'b00 && fmt[1:0] == 2'b10) begin
        addr[1:0] = 2'b00;
      end
      run_model(op, fmt, addr, r3, model_data, model_fault);
      send_request(op, fmt, addr - sign_extend(r2[31:20]), r2[31:20], r3,
                   model_data, model_fault);
    end

    @(posedge clock);
    #2;
    req_valid = 1'b0;

    wait_count = 0;
    while (exp_data_q.size() != 0 && wait_count < 20) begin
      @(posedge clock);
      wait_count++;
    end
    if (exp_data_q.size() != 0) begin
      $display("ERROR timed out with %0d results missing", exp_data_q.size());
      error_count++;
    end
    // catch any stray result after the drain
    repeat (3) @(posedge clock);

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
